// ==== rtl/lsu_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, enums and structs of the load/store unit
////////////////////////////////////////////////////////////

`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and limits
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W          = 32;  // Byte address
  localparam int unsigned DATA_W          = 32;  // Bus data word
  localparam int unsigned BE_W            = DATA_W / 8;
  localparam int unsigned MAX_OUTSTANDING = 2;   // Bus transfers in flight
  localparam int unsigned CNT_W           = 2;   // Holds 0..MAX_OUTSTANDING

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  // Access size, same coding as the funct3 low bits
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  typedef enum logic {
    SPLIT_FIRST  = 1'b0,  // First (or only) address phase
    SPLIT_SECOND = 1'b1   // Second phase of a misaligned access
  } split_state_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Request from the execute stage
  typedef struct packed {
    logic [ADDR_W-1:0] operand_a;  // Base register
    logic [ADDR_W-1:0] operand_b;  // Offset
    logic [DATA_W-1:0] wdata;      // Store data, unaligned
    logic              we;
    lsu_size_e         size;
    logic              sext;       // Sign extend loads
  } lsu_op_t;

  // Bus request payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  // Travels with each accepted transfer to the response side
  typedef struct packed {
    lsu_size_e size;
    logic      sext;
    logic      we;
    logic [1:0] offset;  // Byte offset of the original address
    logic      last;     // Low only for the first part of a split
  } lsu_ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_req_align.sv ====
////////////////////////////////////////////////////////////
// Request side: address, split tracking, byte enables and
// write data lane rotation
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_req_align (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               valid_i,
  input  wire lsu_pkg::lsu_op_t   op_i,
  input  wire logic               accept_i,     // Bus took the current part
  output      logic               req_valid_o,
  output      lsu_pkg::obi_req_t  req_o,
  output      lsu_pkg::lsu_ctrl_t ctrl_o,
  output      logic               split_o,
  output      logic               last_o        // Last part accepted
);

  logic [lsu_pkg::ADDR_W-1:0] addr;       // Effective address
  logic [1:0]                 offset;
  logic                       needs_split;
  lsu_pkg::split_state_e      split_q;
  logic [lsu_pkg::BE_W-1:0]   be;
  logic [lsu_pkg::DATA_W-1:0] wdata;

  assign addr   = op_i.operand_a + op_i.operand_b;
  assign offset = addr[1:0];

  // Word not on a word boundary, or half crossing into the next word
  assign needs_split = ((op_i.size == lsu_pkg::SIZE_WORD) && (offset != 2'b00)) ||
                       ((op_i.size == lsu_pkg::SIZE_HALF) && (offset == 2'b11));

  // Only the first part of a split still has a second one pending
  assign split_o = valid_i && needs_split && (split_q == lsu_pkg::SPLIT_FIRST);
  assign last_o  = accept_i && !split_o;

  ////////////////////////////////////////////////////////////
  // Split state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= lsu_pkg::SPLIT_FIRST;
    end else if (!valid_i) begin
      split_q <= lsu_pkg::SPLIT_FIRST;  // No instruction, start clean
    end else if (accept_i) begin
      split_q <= split_o ? lsu_pkg::SPLIT_SECOND : lsu_pkg::SPLIT_FIRST;
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    be = '0;
    case (op_i.size)
      lsu_pkg::SIZE_BYTE: be = 4'b0001 << offset;  // One lane
      lsu_pkg::SIZE_HALF: begin
        if (split_q == lsu_pkg::SPLIT_FIRST)
          be = 4'b0011 << offset;   // Offset 3 keeps only the top lane
        else
          be = 4'b0001;             // Upper byte in lane 0 of next word
      end
      default: begin                // Word
        if (split_q == lsu_pkg::SPLIT_FIRST) begin
          be = 4'b1111 << offset;
        end else begin
          case (offset)             // Remaining low lanes
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            2'b11:   be = 4'b0111;
            default: be = 4'b0000;  // Aligned word never gets here
          endcase
        end
      end
    endcase
  end

  // Rotate store data left by the byte offset, same for both parts
  always_comb begin
    case (offset)
      2'b01:   wdata = {op_i.wdata[23:0], op_i.wdata[31:24]};
      2'b10:   wdata = {op_i.wdata[15:0], op_i.wdata[31:16]};
      2'b11:   wdata = {op_i.wdata[7:0],  op_i.wdata[31:8]};
      default: wdata = op_i.wdata;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Outputs to the bus master and response side
  ////////////////////////////////////////////////////////////

  assign req_valid_o = valid_i;

  always_comb begin
    req_o.addr  = (split_q == lsu_pkg::SPLIT_SECOND) ?
                  {addr[lsu_pkg::ADDR_W-1:2], 2'b00} + lsu_pkg::ADDR_W'(4) :  // Next word
                  addr;
    req_o.we    = op_i.we;
    req_o.be    = be;
    req_o.wdata = wdata;
  end

  always_comb begin
    ctrl_o.size   = op_i.size;
    ctrl_o.sext   = op_i.sext;
    ctrl_o.we     = op_i.we;
    ctrl_o.offset = offset;
    ctrl_o.last   = !split_o;  // First half of a split is not last
  end

endmodule

`default_nettype wire

// ==== rtl/lsu_obi_master.sv ====
////////////////////////////////////////////////////////////
// Bus master: outstanding counter, request and accept
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_obi_master (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              req_valid_i,  // Part ready to issue
  input  wire lsu_pkg::obi_req_t req_i,
  output      logic              accept_o,     // req_o and gnt_i together
  input  wire logic              gnt_i,
  input  wire logic              rvalid_i,
  output      logic              req_o,
  output      lsu_pkg::obi_req_t obi_req_o,
  output      logic              busy_o
);

  logic [lsu_pkg::CNT_W-1:0] cnt_q;     // Transfers in flight
  logic [lsu_pkg::CNT_W-1:0] cnt_d;
  logic                      cnt_full;
  logic                      count_up;
  logic                      count_down;

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////

  assign cnt_full = (cnt_q >= lsu_pkg::CNT_W'(lsu_pkg::MAX_OUTSTANDING));

  // Hold off new requests while the response side is full
  assign req_o    = req_valid_i && !cnt_full;
  assign accept_o = req_o && gnt_i;

  // Payload straight from the aligner, stable while valid is held
  assign obi_req_o = req_i;

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  assign count_up   = accept_o;   // Address phase done
  assign count_down = rvalid_i;   // Response phase done

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;        // Idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Busy with transfers in flight or a request still waiting
  assign busy_o = (cnt_q != '0) || req_valid_i;

endmodule

`default_nettype wire

// ==== rtl/lsu_resp_align.sv ====
////////////////////////////////////////////////////////////
// Response side: control queue, read data realignment,
// extension and error merge
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_resp_align (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       accept_i,  // Push ctrl_i
  input  wire lsu_pkg::lsu_ctrl_t         ctrl_i,
  input  wire logic                       rvalid_i,  // Pop head
  input  wire logic [lsu_pkg::DATA_W-1:0] rdata_i,
  input  wire logic                       err_i,
  output      logic                       result_valid_o,
  output      logic [lsu_pkg::DATA_W-1:0] result_rdata_o,
  output      logic                       result_err_o
);

  lsu_pkg::lsu_ctrl_t           ctrl_q [lsu_pkg::MAX_OUTSTANDING];
  logic                         wr_ptr_q;
  logic                         rd_ptr_q;
  lsu_pkg::lsu_ctrl_t           head;         // Control of the answering transfer
  logic [lsu_pkg::DATA_W-1:0]   rdata_q;      // First part raw data
  logic                         err_q;        // First part error
  logic                         is_split;
  logic [2*lsu_pkg::DATA_W-1:0] rdata_full;
  logic [lsu_pkg::DATA_W-1:0]   rdata_aligned;

  ////////////////////////////////////////////////////////////
  // Control queue, one entry per transfer in flight
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept_i)
      ctrl_q[wr_ptr_q] <= ctrl_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (accept_i) wr_ptr_q <= !wr_ptr_q;
      if (rvalid_i) rd_ptr_q <= !rd_ptr_q;  // rvalid always follows its grant
    end
  end

  assign head = ctrl_q[rd_ptr_q];

  ////////////////////////////////////////////////////////////
  // First part capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rvalid_i && !head.last) begin
      err_q <= err_i;
      if (!head.we)
        rdata_q <= rdata_i;   // Stores carry no read data
    end
  end

  ////////////////////////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////////////////////////

  // Same rule as the request side, taken from the stored control
  assign is_split = ((head.size == lsu_pkg::SIZE_WORD) && (head.offset != 2'b00)) ||
                    ((head.size == lsu_pkg::SIZE_HALF) && (head.offset == 2'b11));

  // New word above the stored low part, or doubled when not split
  assign rdata_full    = is_split ? {rdata_i, rdata_q} : {rdata_i, rdata_i};
  assign rdata_aligned = rdata_full[{head.offset, 3'b000} +: lsu_pkg::DATA_W];

  always_comb begin
    case (head.size)
      lsu_pkg::SIZE_BYTE:
        result_rdata_o = {{24{head.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      lsu_pkg::SIZE_HALF:
        result_rdata_o = {{16{head.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:
        result_rdata_o = rdata_aligned;  // Word
    endcase
  end

  // One strobe per instruction, on its last part
  assign result_valid_o = rvalid_i && head.last;
  assign result_err_o   = err_i || (is_split && err_q);

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
////////////////////////////////////////////////////////////
// Load/store unit top, request, bus and response stages
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_top (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  // Execute port
  input  wire logic                       valid_i,
  input  wire lsu_pkg::lsu_op_t           op_i,
  output      logic                       ready_o,
  output      logic                       split_o,
  // Result port
  output      logic                       result_valid_o,
  output      logic [lsu_pkg::DATA_W-1:0] result_rdata_o,
  output      logic                       result_err_o,
  // Data bus
  output      logic                       req_o,
  output      lsu_pkg::obi_req_t          obi_req_o,
  input  wire logic                       gnt_i,
  input  wire logic                       rvalid_i,
  input  wire logic [lsu_pkg::DATA_W-1:0] rdata_i,
  input  wire logic                       err_i,
  output      logic                       busy_o
);

  logic               req_valid;   // Aligner has a part to issue
  lsu_pkg::obi_req_t  align_req;   // Aligned bus payload
  lsu_pkg::lsu_ctrl_t align_ctrl;  // Control of that part
  logic               accept;      // Part taken by the bus

  lsu_req_align i_lsu_req_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .accept_i    (accept),
    .req_valid_o (req_valid),
    .req_o       (align_req),
    .ctrl_o      (align_ctrl),
    .split_o     (split_o),
    .last_o      (ready_o)      // Last part accepted frees the execute stage
  );

  lsu_obi_master i_lsu_obi_master (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_i       (align_req),
    .accept_o    (accept),
    .gnt_i       (gnt_i),
    .rvalid_i    (rvalid_i),
    .req_o       (req_o),
    .obi_req_o   (obi_req_o),
    .busy_o      (busy_o)
  );

  lsu_resp_align i_lsu_resp_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .accept_i       (accept),
    .ctrl_i         (align_ctrl),
    .rvalid_i       (rvalid_i),
    .rdata_i        (rdata_i),
    .err_i          (err_i),
    .result_valid_o (result_valid_o),
    .result_rdata_o (result_rdata_o),
    .result_err_o   (result_err_o)
  );

endmodule

`default_nettype wire

// ==== test/lsu_props.sv ====
////////////////////////////////////////////////////////////
// Bus and outstanding counter properties, bound to the
// bus master
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lsu_props (
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire logic                      req_o,
  input wire lsu_pkg::obi_req_t         obi_req_o,
  input wire logic                      gnt_i,
  input wire logic                      rvalid_i,
  input wire logic [lsu_pkg::CNT_W-1:0] cnt_q
);

  // Request stays up until granted
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    req_o && !gnt_i |=> req_o)
    else $error("req_o dropped before gnt_i");

  // Payload frozen while waiting for the grant
  payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_o && !gnt_i |=> $stable(obi_req_o))
    else $error("obi_req_o changed before gnt_i");

  cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= lsu_pkg::CNT_W'(lsu_pkg::MAX_OUTSTANDING))
    else $error("outstanding counter above limit");

  // Every response needs a transfer in flight
  rvalid_owed: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> cnt_q != '0)
    else $error("rvalid_i with no transfer in flight");

endmodule

bind lsu_obi_master lsu_props i_lsu_props (
  .clk(clk), .rst_n(rst_n), .req_o(req_o), .obi_req_o(obi_req_o),
  .gnt_i(gnt_i), .rvalid_i(rvalid_i), .cnt_q(cnt_q)
);

`default_nettype wire

// ==== test/tb_lsu.sv ====
////////////////////////////////////////////////////////////
// Load/store unit testbench, OBI memory model, directed tests
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

  typedef struct packed {
    logic [31:0]        addr;   // Effective byte address
    logic [31:0]        wdata;  // Unaligned store data
    logic               we;
    lsu_pkg::lsu_size_e size;
    logic               sext;
  } op_rec_t;

  typedef struct packed {
    logic [31:0] rdata;  // Extended load value
    logic        err;
    logic        we;
  } exp_t;

  typedef struct packed {
    logic [31:0] ready_at;  // Cycle from which rvalid may rise
    logic [31:0] rdata;
    logic        err;
  } resp_t;

  typedef struct packed {
    logic [3:0]  be;
    logic [31:0] wdata;  // Only enabled lanes are meaningful
  } lanes_t;

  logic                       clk;
  logic                       rst_n;
  logic                       valid_i;
  lsu_pkg::lsu_op_t           op_i;
  logic                       ready_o;
  logic                       split_o;
  logic                       result_valid_o;
  logic [lsu_pkg::DATA_W-1:0] result_rdata_o;
  logic                       result_err_o;
  logic                       req_o;
  lsu_pkg::obi_req_t          obi_req_o;
  logic                       gnt_i;
  logic                       rvalid_i;
  logic [lsu_pkg::DATA_W-1:0] rdata_i;
  logic                       err_i;
  logic                       busy_o;

  logic [7:0]  mem [logic [31:0]];  // Bytes written by stores
  op_rec_t     op_q[$];             // Issued, not yet fully accepted
  exp_t        exp_q[$];            // Expected results, in order
  resp_t       resp_q[$];           // Accepted, waiting for rvalid
  logic [31:0] lfsr_q;
  logic        slow_rvalid;         // Immediate grant, latest rvalid
  int          gnt_wait;
  int          cycle_cnt;
  int          part_idx;
  int          inflight;
  int          max_inflight;
  int          issued_cnt;
  int          result_cnt;
  int          check_cnt;
  int          err_cnt;

  lsu_top i_lsu_top (
    .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .op_i(op_i), .ready_o(ready_o),
    .split_o(split_o), .result_valid_o(result_valid_o), .result_rdata_o(result_rdata_o),
    .result_err_o(result_err_o), .req_o(req_o), .obi_req_o(obi_req_o), .gnt_i(gnt_i),
    .rvalid_i(rvalid_i), .rdata_i(rdata_i), .err_i(err_i), .busy_o(busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic int take_bits(input int n);
    int   v;
    int   i;
    logic fb;
    v = 0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  function automatic int size_bytes(input lsu_pkg::lsu_size_e s);
    return (s == lsu_pkg::SIZE_BYTE) ? 1 : (s == lsu_pkg::SIZE_HALF) ? 2 : 4;
  endfunction

  function automatic logic [31:0] word_of(input logic [31:0] a);
    return {a[31:2], 2'b00};
  endfunction

  function automatic logic [7:0] read_byte(input logic [31:0] a);
    // Unwritten bytes follow a pattern of the full address
    return mem.exists(a) ? mem[a] : (a[7:0] ^ {a[12:8], a[15:13]} ^ a[23:16] ^ a[31:24]);
  endfunction

  function automatic logic [31:0] extend(input logic [31:0] v, input lsu_pkg::lsu_size_e s,
                                         input logic sx);
    case (s)
      lsu_pkg::SIZE_BYTE: return {{24{sx & v[7]}}, v[7:0]};
      lsu_pkg::SIZE_HALF: return {{16{sx & v[15]}}, v[15:0]};
      default:            return v;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // Lanes of one bus part, byte by byte from the access footprint
  function automatic lanes_t part_lanes(input op_rec_t op, input int part);
    lanes_t      ln;
    logic [31:0] word;
    logic [31:0] b;
    int          i;
    ln   = '0;
    word = word_of(op.addr) + ((part == 1) ? 32'd4 : 32'd0);
    for (i = 0; i < size_bytes(op.size); i++) begin
      b = op.addr + i;
      if (word_of(b) == word) begin
        ln.be[b[1:0]]           = 1'b1;
        ln.wdata[8*b[1:0] +: 8] = op.wdata[8*i +: 8];
      end
    end
    return ln;
  endfunction

  function automatic op_rec_t make_op(input logic we, input lsu_pkg::lsu_size_e s,
                                      input logic sx, input logic [31:0] a,
                                      input logic [31:0] d);
    op_rec_t op;
    op.addr  = a;
    op.wdata = d;
    op.we    = we;
    op.size  = s;
    op.sext  = sx;
    return op;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_cnt++;
    assert (cond) else begin
      err_cnt++;
      $display("Failure at %0t: %s", $time, what);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // OBI memory model and monitors
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    op_rec_t     op;
    lanes_t      ln;
    resp_t       rsp;
    logic [31:0] word;
    int          n_parts;
    int          lat;
    int          i;
    if (rst_n) begin
      cycle_cnt++;
      if (rvalid_i) begin
        void'(resp_q.pop_front());  // Response phase done
        inflight--;
      end
      if (req_o && gnt_i) begin
        check_true(op_q.size() != 0, "bus transfer without a pending instruction");
        if (op_q.size() != 0) begin
          op      = op_q[0];
          n_parts = (word_of(op.addr) != word_of(op.addr + size_bytes(op.size) - 1)) ? 2 : 1;
          ln      = part_lanes(op, part_idx);
          check_value("obi_req_o.addr", obi_req_o.addr,
                      (part_idx == 0) ? op.addr : word_of(op.addr) + 32'd4);
          check_value("obi_req_o.we", obi_req_o.we, op.we);
          check_value("obi_req_o.be", obi_req_o.be, ln.be);
          check_value("split_o", split_o, (part_idx == 0) && (n_parts == 2));
          if (op.we)
            check_value("obi_req_o.wdata", obi_req_o.wdata & lane_mask(ln.be), ln.wdata);
          if (ready_o) begin  // Last part of the instruction
            check_true(part_idx + 1 == n_parts, "instruction ended with a part missing");
            void'(op_q.pop_front());
            part_idx = 0;
          end else begin
            part_idx++;
            check_true(part_idx < n_parts, "more bus transfers than the access needs");
          end
        end
        word    = word_of(obi_req_o.addr);
        rsp.err = obi_req_o.addr[31];  // Upper half of the map answers with err
        for (i = 0; i < 4; i++) begin
          if (obi_req_o.we && obi_req_o.be[i] && !rsp.err)
            mem[word + i] = obi_req_o.wdata[8*i +: 8];
          rsp.rdata[8*i +: 8] = read_byte(word + i);
        end
        lat          = slow_rvalid ? 3 : 1 + take_bits(1) + take_bits(1);  // 1 to 3
        rsp.ready_at = cycle_cnt + lat - 1;
        resp_q.push_back(rsp);
        inflight++;
        if (inflight > max_inflight) max_inflight = inflight;
        check_true(inflight <= lsu_pkg::MAX_OUTSTANDING, "too many transfers in flight");
        gnt_wait = slow_rvalid ? 0 : take_bits(2);  // Next grant after 0 to 3 cycles
      end else if (req_o && gnt_wait > 0) begin
        gnt_wait--;
      end
    end
  end

  // Bus outputs change on the falling edge, in order from the head
  always @(negedge clk) begin
    gnt_i <= (gnt_wait == 0);
    if (resp_q.size() != 0 && cycle_cnt >= int'(resp_q[0].ready_at)) begin
      rvalid_i <= 1'b1;
      rdata_i  <= resp_q[0].rdata;
      err_i    <= resp_q[0].err;
    end else begin
      rvalid_i <= 1'b0;
      rdata_i  <= '0;
      err_i    <= 1'b0;
    end
  end

  always @(posedge clk) begin
    exp_t e;
    if (rst_n && result_valid_o) begin
      result_cnt++;
      check_true(exp_q.size() != 0, "result strobe with no instruction pending");
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_value("result_err_o", result_err_o, e.err);
        if (!e.we && !e.err) check_value("result_rdata_o", result_rdata_o, e.rdata);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Execute port driving
  ////////////////////////////////////////////////////////////

  // Called on a falling edge, returns on the falling edge after ready_o
  task automatic issue_op(input op_rec_t op);
    exp_t        e;
    logic [31:0] last;
    int          i;
    int          t;
    last    = op.addr + size_bytes(op.size) - 1;
    e.we    = op.we;
    e.err   = op.addr[31] | last[31];  // Either part in the error region
    e.rdata = '0;
    for (i = 0; i < size_bytes(op.size); i++)
      e.rdata[8*i +: 8] = read_byte(op.addr + i);
    e.rdata = extend(e.rdata, op.size, op.sext);
    op_q.push_back(op);
    exp_q.push_back(e);
    issued_cnt++;
    valid_i         = 1'b1;
    op_i.operand_a  = op.addr - 32'h40;  // Exercise the address adder
    op_i.operand_b  = 32'h40;
    op_i.wdata      = op.wdata;
    op_i.we         = op.we;
    op_i.size       = op.size;
    op_i.sext       = op.sext;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!ready_o && t < 100);
    check_true(ready_o, "timed out waiting for ready_o");
    @(negedge clk);
    valid_i = 1'b0;
  endtask

  task automatic check_idle();
    check_value("req_o", req_o, 32'd0);
    check_value("ready_o", ready_o, 32'd0);
    check_value("busy_o", busy_o, 32'd0);
  endtask

  task automatic wait_results();
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (result_cnt != issued_cnt && t < 200);
    check_true(result_cnt == issued_cnt, "timed out waiting for result strobes");
    check_idle();
  endtask

  task automatic store_op(input logic [31:0] a, input lsu_pkg::lsu_size_e s,
                          input logic [31:0] d);
    int i;
    issue_op(make_op(1'b1, s, 1'b0, a, d));
    wait_results();
    if (!a[31]) begin  // Memory must now hold the store bytes
      for (i = 0; i < size_bytes(s); i++)
        check_value("memory byte", read_byte(a + i), d[8*i +: 8]);
    end
  endtask

  task automatic load_op(input logic [31:0] a, input lsu_pkg::lsu_size_e s, input logic sx);
    issue_op(make_op(1'b0, s, sx, a, 32'h0));
    wait_results();
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state();
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_idle();
  endtask

  task automatic aligned_stores_loads();
    store_op(32'h100, lsu_pkg::SIZE_WORD, 32'h8bad_f00d);
    load_op(32'h100, lsu_pkg::SIZE_WORD, 1'b0);
    store_op(32'h106, lsu_pkg::SIZE_HALF, 32'h1234_c3a7);
    load_op(32'h106, lsu_pkg::SIZE_HALF, 1'b1);   // Negative half
    load_op(32'h106, lsu_pkg::SIZE_HALF, 1'b0);
    store_op(32'h10b, lsu_pkg::SIZE_BYTE, 32'h0000_009e);
    load_op(32'h10b, lsu_pkg::SIZE_BYTE, 1'b1);
    load_op(32'h10b, lsu_pkg::SIZE_BYTE, 1'b0);
    load_op(32'h109, lsu_pkg::SIZE_BYTE, 1'b1);   // Fill pattern
    load_op(32'h140, lsu_pkg::SIZE_WORD, 1'b0);
  endtask

  task automatic misaligned_accesses();
    store_op(32'h201, lsu_pkg::SIZE_WORD, 32'hdead_beef);
    load_op(32'h201, lsu_pkg::SIZE_WORD, 1'b0);
    store_op(32'h212, lsu_pkg::SIZE_WORD, 32'h1357_9bdf);
    load_op(32'h212, lsu_pkg::SIZE_WORD, 1'b0);
    store_op(32'h223, lsu_pkg::SIZE_WORD, 32'h2468_ace0);
    load_op(32'h223, lsu_pkg::SIZE_WORD, 1'b0);
    store_op(32'h233, lsu_pkg::SIZE_HALF, 32'h0000_8a5b);  // Half over a word edge
    load_op(32'h233, lsu_pkg::SIZE_HALF, 1'b1);
    load_op(32'h203, lsu_pkg::SIZE_WORD, 1'b0);
  endtask

  task automatic back_to_back_loads();
    slow_rvalid  = 1'b1;
    max_inflight = 0;
    issue_op(make_op(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h100, 32'h0));
    issue_op(make_op(1'b0, lsu_pkg::SIZE_HALF, 1'b1, 32'h106, 32'h0));
    issue_op(make_op(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h201, 32'h0));
    issue_op(make_op(1'b0, lsu_pkg::SIZE_BYTE, 1'b0, 32'h10b, 32'h0));
    issue_op(make_op(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h212, 32'h0));
    wait_results();
    check_value("max_inflight", max_inflight, lsu_pkg::MAX_OUTSTANDING);
    slow_rvalid = 1'b0;
  endtask

  task automatic bus_error_responses();
    load_op(32'h8000_0010, lsu_pkg::SIZE_WORD, 1'b0);
    store_op(32'h8000_0021, lsu_pkg::SIZE_BYTE, 32'h55);
    load_op(32'h7fff_fffe, lsu_pkg::SIZE_WORD, 1'b0);  // Second part errs
    load_op(32'hffff_fffd, lsu_pkg::SIZE_WORD, 1'b0);  // First part errs
    load_op(32'h0000_0100, lsu_pkg::SIZE_WORD, 1'b0);  // Clean again
  endtask

  initial begin
    rst_n        = 1'b0;
    valid_i      = 1'b0;
    op_i         = '0;
    gnt_i        = 1'b0;
    rvalid_i     = 1'b0;
    rdata_i      = '0;
    err_i        = 1'b0;
    lfsr_q       = 32'hec4f5b25;
    slow_rvalid  = 1'b0;
    gnt_wait     = 0;
    cycle_cnt    = 0;
    part_idx     = 0;
    inflight     = 0;
    max_inflight = 0;
    issued_cnt   = 0;
    result_cnt   = 0;
    check_cnt    = 0;
    err_cnt      = 0;
    reset_state();
    aligned_stores_loads();
    misaligned_accesses();
    back_to_back_loads();
    bus_error_responses();
    $display("Checks: %0d, failed: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/lsu_pkg.sv
rtl/lsu_req_align.sv
rtl/lsu_obi_master.sv
rtl/lsu_resp_align.sv
rtl/lsu_top.sv
test/lsu_props.sv
test/tb_lsu.sv

// ==== Bender.yml ====
package:
  name: lsu

# Load/store unit with OBI data bus

sources:
  # Design, package first
  - files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_req_align.sv
      - rtl/lsu_obi_master.sv
      - rtl/lsu_resp_align.sv
      - rtl/lsu_top.sv

  # Testbench and bound properties
  - target: test
    files:
      - test/lsu_props.sv
      - test/tb_lsu.sv

# Simulation top is tb_lsu, design top is lsu_top
